// ==== project.f ====
design/axil_pkg.sv
design/wb_pkg.sv
design/wb_bus_if.sv
design/axil_wr_to_wb.sv
design/axil_rd_to_wb.sv
design/wb_rw_arbiter.sv
design/axil_to_wb_bridge.sv
tb/tb_clk_gen.sv
tb/tb_axil_to_wb_assert.sv
tb/tb_axil_to_wb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_axil_to_wb -f project.f -o sim_tb \
	&& ./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

# Pass only when the testbench printed its pass line
grep -q "^STATUS: PASS$" sim.log 2>/dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== tb/tb_axil_to_wb.sv ====
`timescale 1ns/1ps

module tb_axil_to_wb;
	localparam int ADDR_WIDTH = axil_pkg::ADDR_WIDTH_DEF;
	localparam int DATA_WIDTH = axil_pkg::DATA_WIDTH_DEF;
	localparam int LGFIFO     = 4;
	localparam int DEPTH      = 2**LGFIFO;
	localparam int WB_AW      = ADDR_WIDTH - 2;
	localparam int TIMEOUT    = 2000;
	// B/R ready behavior
	localparam int READY_ON   = 0;
	localparam int READY_HOLD = 1;
	localparam int READY_RAND = 2;
	// Top address bit where the slave answers err
	localparam logic [ADDR_WIDTH-1:0] ERR_BASE = 28'h800_0000;

	logic clk;
	logic arst_n;

	// AXI-Lite side
	logic axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_bvalid, axi_bready;
	logic axi_arvalid, axi_arready, axi_rvalid, axi_rready;
	logic [ADDR_WIDTH-1:0] axi_awaddr, axi_araddr;
	logic [DATA_WIDTH-1:0] axi_wdata, axi_rdata;
	logic [3:0]            axi_wstrb;
	axil_pkg::prot_t       axi_awprot, axi_arprot;
	axil_pkg::resp_t       axi_bresp, axi_rresp;

	// Wishbone side
	logic wb_cyc, wb_stb, wb_we, wb_stall, wb_ack, wb_err;
	logic [WB_AW-1:0]      wb_addr;
	logic [DATA_WIDTH-1:0] wb_odata, wb_idata;
	logic [3:0]            wb_sel;

	// Expected responses in issue order
	axil_pkg::resp_t exp_bresp[$];
	logic [33:0]     exp_r[$];
	logic [31:0]     shadow [256];
	int              pending_w = 0;
	int              pending_r = 0;
	int              b_mode = READY_ON;
	int              r_mode = READY_ON;

	// Slave model state
	logic [31:0] mem [256];
	int          ack_due[$];
	logic        ack_err[$];
	logic [31:0] ack_data[$];
	int          cycle_n = 0;
	int          last_due = -1;
	logic        cyc_prev = 1'b0;
	logic        we_prev = 1'b0;

	tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clk (.o_clk(clk), .o_arst_n(arst_n));

	axil_to_wb_bridge #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.LGFIFO     (LGFIFO)
	) dut0 (
		.i_clk         (clk),
		.i_arst_n      (arst_n),
		.i_axi_awvalid (axi_awvalid),
		.o_axi_awready (axi_awready),
		.i_axi_awaddr  (axi_awaddr),
		.i_axi_awprot  (axi_awprot),
		.i_axi_wvalid  (axi_wvalid),
		.o_axi_wready  (axi_wready),
		.i_axi_wdata   (axi_wdata),
		.i_axi_wstrb   (axi_wstrb),
		.o_axi_bvalid  (axi_bvalid),
		.i_axi_bready  (axi_bready),
		.o_axi_bresp   (axi_bresp),
		.i_axi_arvalid (axi_arvalid),
		.o_axi_arready (axi_arready),
		.i_axi_araddr  (axi_araddr),
		.i_axi_arprot  (axi_arprot),
		.o_axi_rvalid  (axi_rvalid),
		.i_axi_rready  (axi_rready),
		.o_axi_rdata   (axi_rdata),
		.o_axi_rresp   (axi_rresp),
		.o_wb_cyc      (wb_cyc),
		.o_wb_stb      (wb_stb),
		.o_wb_we       (wb_we),
		.o_wb_addr     (wb_addr),
		.o_wb_data     (wb_odata),
		.o_wb_sel      (wb_sel),
		.i_wb_stall    (wb_stall),
		.i_wb_ack      (wb_ack),
		.i_wb_data     (wb_idata),
		.i_wb_err      (wb_err)
	);

	//////////////////////////////////////////////////////////////////////
	// Error reporting and helpers
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("[ERROR] %0t: %s", $time, why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] %0t: %s = %h, expected %h", $time, sig, got, exp);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	endtask

	// Initial memory word built from every index bit
	function automatic logic [31:0] fill_word(input int i);
		return {8'(i), ~8'(i), 8'(i) ^ 8'h3c, 8'(i) + 8'ha5};
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] byte_addr(input int idx);
		return ADDR_WIDTH'(idx) << 2;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// AXI request drivers called 1 ns after an edge
	//////////////////////////////////////////////////////////////////////

	task automatic drive_write(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int waited;
		int idx;
		waited = 0;
		idx = int'(addr[9:2]);
		// Expected B and shadow update at issue
		if (addr[ADDR_WIDTH-1])
			exp_bresp.push_back(axil_pkg::RESP_SLVERR);
		else
		begin
			exp_bresp.push_back(axil_pkg::RESP_OKAY);
			for (int b = 0; b < 4; b++)
				if (strb[b])
					shadow[idx][8*b +: 8] = data[8*b +: 8];
		end
		axi_awvalid = 1'b1;
		axi_awaddr  = addr;
		axi_wvalid  = 1'b1;
		axi_wdata   = data;
		axi_wstrb   = strb;
		@(posedge clk);
		while (!axi_awready && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!axi_awready)
			abort_run("write address and data never accepted");
		pending_w++;
		#1;
		axi_awvalid = 1'b0;
		axi_wvalid  = 1'b0;
	endtask

	task automatic drive_read(input logic [ADDR_WIDTH-1:0] addr);
		int waited;
		waited = 0;
		// Error region reads back zero
		if (addr[ADDR_WIDTH-1])
			exp_r.push_back({32'h0, axil_pkg::RESP_SLVERR});
		else
			exp_r.push_back({shadow[int'(addr[9:2])], axil_pkg::RESP_OKAY});
		axi_arvalid = 1'b1;
		axi_araddr  = addr;
		@(posedge clk);
		while (!axi_arready && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (!axi_arready)
			abort_run("read address never accepted");
		pending_r++;
		#1;
		axi_arvalid = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while ((exp_bresp.size() != 0 || exp_r.size() != 0) && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (exp_bresp.size() != 0 || exp_r.size() != 0)
			abort_run("responses still missing after timeout");
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Response checkers and ready drivers
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (arst_n && axi_bvalid && axi_bready)
		begin
			if (exp_bresp.size() == 0)
				abort_run("write response with no write outstanding");
			else
			begin
				assert (axi_bresp == exp_bresp[0])
				else report_mismatch("o_axi_bresp", 32'(axi_bresp), 32'(exp_bresp[0]));
				void'(exp_bresp.pop_front());
				pending_w--;
			end
		end
		#1;
		axi_bready = (b_mode == READY_ON) || (b_mode == READY_RAND && $urandom_range(0, 1) == 1);
	end

	always @(posedge clk)
	begin
		if (arst_n && axi_rvalid && axi_rready)
		begin
			if (exp_r.size() == 0)
				abort_run("read response with no read outstanding");
			else
			begin
				assert (axi_rresp == exp_r[0][1:0])
				else report_mismatch("o_axi_rresp", 32'(axi_rresp), 32'(exp_r[0][1:0]));
				assert (axi_rdata == exp_r[0][33:2])
				else report_mismatch("o_axi_rdata", axi_rdata, exp_r[0][33:2]);
				void'(exp_r.pop_front());
				pending_r--;
			end
		end
		#1;
		axi_rready = (r_mode == READY_ON) || (r_mode == READY_RAND && $urandom_range(0, 1) == 1);
	end

	// Credit limit and bound checker between edges
	always @(negedge clk)
	begin
		if (arst_n && pending_w >= DEPTH)
			assert (!axi_awready)
			else report_mismatch("o_axi_awready", 32'(axi_awready), 32'h0);
		if (arst_n && pending_r >= DEPTH)
			assert (!axi_arready)
			else report_mismatch("o_axi_arready", 32'(axi_arready), 32'h0);
		if (dut0.u_proto_chk.fail_cnt != 0)
			abort_run("bound protocol assertion failed");
	end

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		int due;
		int idx;
		if (arst_n)
		begin
			// One direction per bus cycle
			if (cyc_prev && wb_cyc)
				assert (wb_we == we_prev)
				else abort_run("Wishbone cycle changed direction while open");
			if (wb_cyc && wb_stb && !wb_stall)
			begin
				idx = int'(wb_addr[7:0]);
				// In order and 1 to 3 cycles out
				due = cycle_n + int'($urandom_range(0, 2));
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				ack_due.push_back(due);
				ack_err.push_back(wb_addr[WB_AW-1]);
				ack_data.push_back(mem[idx]);
				if (wb_we && !wb_addr[WB_AW-1])
					for (int b = 0; b < 4; b++)
						if (wb_sel[b])
							mem[idx][8*b +: 8] = wb_odata[8*b +: 8];
			end
		end
		cyc_prev = wb_cyc;
		we_prev  = wb_we;
		#1;
		wb_stall = ($urandom_range(0, 3) == 0);
		wb_ack   = 1'b0;
		wb_err   = 1'b0;
		wb_idata = '0;
		if (ack_due.size() != 0 && ack_due[0] == cycle_n)
		begin
			wb_ack   = !ack_err[0];
			wb_err   = ack_err[0];
			wb_idata = ack_data[0];
			void'(ack_due.pop_front());
			void'(ack_err.pop_front());
			void'(ack_data.pop_front());
		end
		cycle_n++;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int waited;
		void'($urandom(32'h8e4765c1));
		axi_awvalid = 1'b0;
		axi_awaddr  = '0;
		axi_awprot  = '0;
		axi_wvalid  = 1'b0;
		axi_wdata   = '0;
		axi_wstrb   = '0;
		axi_bready  = 1'b1;
		axi_arvalid = 1'b0;
		axi_araddr  = '0;
		axi_arprot  = '0;
		axi_rready  = 1'b1;
		wb_stall    = 1'b0;
		wb_ack      = 1'b0;
		wb_err      = 1'b0;
		wb_idata    = '0;
		for (int i = 0; i < 256; i++)
		begin
			mem[i]    = fill_word(i);
			shadow[i] = fill_word(i);
		end

		waited = 0;
		while (arst_n !== 1'b1 && waited < TIMEOUT)
		begin
			@(posedge clk);
			waited++;
		end
		if (arst_n !== 1'b1)
			abort_run("reset never released");
		// Everything quiet on the first edge out of reset
		assert (!(wb_cyc || wb_stb || axi_bvalid || axi_rvalid || axi_awready
			|| axi_wready || axi_arready))
		else abort_run("control output high right after reset");
		#1;

		// Full write and read back then a partial write on top
		drive_write(byte_addr(16), 32'hdead_beef, 4'b1111);
		wait_drained();
		drive_read(byte_addr(16));
		drive_write(byte_addr(16), 32'h1122_3344, 4'b0101);
		wait_drained();
		drive_read(byte_addr(16));
		wait_drained();

		// Error region on both halves
		drive_write(ERR_BASE | byte_addr(17), 32'hcafe_f00d, 4'b1111);
		drive_read(ERR_BASE | byte_addr(17));
		wait_drained();

		// Back-pressure until both response paths are full
		b_mode = READY_HOLD;
		r_mode = READY_HOLD;
		fork
			for (int i = 0; i < DEPTH + 4; i++)
				drive_write(byte_addr(32 + i), $urandom(), 4'b1111);
			for (int i = 0; i < DEPTH + 4; i++)
				drive_read(byte_addr(96 + i));
			begin
				waited = 0;
				while ((pending_w < DEPTH || pending_r < DEPTH) && waited < TIMEOUT)
				begin
					@(posedge clk);
					waited++;
				end
				if (pending_w < DEPTH || pending_r < DEPTH)
					abort_run("response FIFOs never filled under back-pressure");
				repeat (20) @(posedge clk);
				#1;
				b_mode = READY_RAND;
				r_mode = READY_RAND;
			end
		join
		wait_drained();

		// Both halves at once on disjoint words
		fork
			for (int i = 0; i < 24; i++)
				drive_write(byte_addr(128 + i), $urandom(), 4'($urandom_range(1, 15)));
			for (int i = 0; i < 24; i++)
				drive_read(byte_addr(32 + i));
		join
		wait_drained();

		// Read after write sees the new value
		for (int i = 0; i < 4; i++)
		begin
			drive_write(byte_addr(160 + i), $urandom(), 4'($urandom_range(1, 15)));
			wait_drained();
			drive_read(byte_addr(160 + i));
			wait_drained();
		end

		if (dut0.u_proto_chk.fail_cnt == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
		begin
			$display("STATUS: FAIL");
			$fatal(1, "checks failed at end of run");
		end
	end

endmodule

// ==== tb/tb_axil_to_wb_assert.sv ====
`timescale 1ns/1ps

// Bridge protocol checker, bound to the top level
module tb_axil_to_wb_assert #(
	parameter int DATA_WIDTH = 32
) (
	input logic                  i_clk,
	input logic                  i_arst_n,
	input logic                  i_wb_cyc,
	input logic                  i_wb_stb,
	input logic                  i_awready,
	input logic                  i_wready,
	input logic                  i_arready,
	input logic                  i_bvalid,
	input logic                  i_bready,
	input axil_pkg::resp_t       i_bresp,
	input logic                  i_rvalid,
	input logic                  i_rready,
	input logic [DATA_WIDTH-1:0] i_rdata,
	input axil_pkg::resp_t       i_rresp
);
	// Failed assertions so far, watched from the testbench top
	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// Wishbone side
	//////////////////////////////////////////////////////////////////////

	// No strobe outside a bus cycle
	a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wb_stb |-> i_wb_cyc)
	else
	begin
		$error("wb stb high while cyc is low");
		fail_cnt = fail_cnt + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// AXI side
	//////////////////////////////////////////////////////////////////////

	// B held with stable payload until taken
	a_b_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
	else
	begin
		$error("bvalid dropped or bresp changed before bready");
		fail_cnt = fail_cnt + 1;
	end

	// Same for R, data included
	a_r_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rvalid && !i_rready |=> i_rvalid && $stable(i_rresp) && $stable(i_rdata))
	else
	begin
		$error("rvalid dropped or R payload changed before rready");
		fail_cnt = fail_cnt + 1;
	end

	// AW and W always accepted together
	a_aw_w_pair: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_awready == i_wready)
	else
	begin
		$error("awready and wready differ");
		fail_cnt = fail_cnt + 1;
	end

	// Quiet while in reset
	a_reset_quiet: assert property (@(posedge i_clk)
		!i_arst_n |-> !(i_wb_cyc || i_wb_stb || i_bvalid || i_rvalid
			|| i_awready || i_wready || i_arready))
	else
	begin
		$error("control output high during reset");
		fail_cnt = fail_cnt + 1;
	end

endmodule

bind axil_to_wb_bridge tb_axil_to_wb_assert #(
	.DATA_WIDTH (DATA_WIDTH)
) u_proto_chk (
	.i_clk     (i_clk),
	.i_arst_n  (i_arst_n),
	.i_wb_cyc  (o_wb_cyc),
	.i_wb_stb  (o_wb_stb),
	.i_awready (o_axi_awready),
	.i_wready  (o_axi_wready),
	.i_arready (o_axi_arready),
	.i_bvalid  (o_axi_bvalid),
	.i_bready  (i_axi_bready),
	.i_bresp   (o_axi_bresp),
	.i_rvalid  (o_axi_rvalid),
	.i_rready  (i_axi_rready),
	.i_rdata   (o_axi_rdata),
	.i_rresp   (o_axi_rresp)
);

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

// Free-running clock and a power-on reset
module tb_clk_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 4
) (
	output logic o_clk,
	output logic o_arst_n
);
	initial
	begin
		o_clk    = 1'b0;
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		// Release just after an edge
		#1 o_arst_n = 1'b1;
	end

	always #(PERIOD_NS/2) o_clk = ~o_clk;

endmodule

// ==== design/axil_to_wb_bridge.sv ====
`timescale 1ns/1ps

module axil_to_wb_bridge #(
	parameter int ADDR_WIDTH = axil_pkg::ADDR_WIDTH_DEF,
	parameter int DATA_WIDTH = axil_pkg::DATA_WIDTH_DEF,
	parameter int LGFIFO     = 4,
	localparam int WB_AW     = ADDR_WIDTH - $clog2(DATA_WIDTH/8)
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	// AXI-Lite write address
	input  logic                    i_axi_awvalid,
	output logic                    o_axi_awready,
	input  logic [ADDR_WIDTH-1:0]   i_axi_awaddr,
	input  axil_pkg::prot_t         i_axi_awprot,
	// AXI-Lite write data
	input  logic                    i_axi_wvalid,
	output logic                    o_axi_wready,
	input  logic [DATA_WIDTH-1:0]   i_axi_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_axi_wstrb,
	// AXI-Lite write response
	output logic                    o_axi_bvalid,
	input  logic                    i_axi_bready,
	output axil_pkg::resp_t         o_axi_bresp,
	// AXI-Lite read address
	input  logic                    i_axi_arvalid,
	output logic                    o_axi_arready,
	input  logic [ADDR_WIDTH-1:0]   i_axi_araddr,
	input  axil_pkg::prot_t         i_axi_arprot,
	// AXI-Lite read data
	output logic                    o_axi_rvalid,
	input  logic                    i_axi_rready,
	output logic [DATA_WIDTH-1:0]   o_axi_rdata,
	output axil_pkg::resp_t         o_axi_rresp,
	// Pipelined Wishbone master
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output logic                    o_wb_we,
	output logic [WB_AW-1:0]        o_wb_addr,
	output logic [DATA_WIDTH-1:0]   o_wb_data,
	output logic [DATA_WIDTH/8-1:0] o_wb_sel,
	input  logic                    i_wb_stall,
	input  logic                    i_wb_ack,
	input  logic [DATA_WIDTH-1:0]   i_wb_data,
	input  logic                    i_wb_err
);
	// Per-half buses into the arbiter
	wb_bus_if #(.AW(WB_AW), .DW(DATA_WIDTH)) wb_rd ();
	wb_bus_if #(.AW(WB_AW), .DW(DATA_WIDTH)) wb_wr ();

	// AW + W merged, B queued
	axil_wr_to_wb #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.LGFIFO     (LGFIFO)
	) u_wr (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_awvalid (i_axi_awvalid),
		.o_awready (o_axi_awready),
		.i_awaddr  (i_axi_awaddr),
		.i_wvalid  (i_axi_wvalid),
		.o_wready  (o_axi_wready),
		.i_wdata   (i_axi_wdata),
		.i_wstrb   (i_axi_wstrb),
		.o_bvalid  (o_axi_bvalid),
		.i_bready  (i_axi_bready),
		.o_bresp   (o_axi_bresp),
		.wb        (wb_wr.master)
	);

	// AR forwarded, R queued
	axil_rd_to_wb #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.LGFIFO     (LGFIFO)
	) u_rd (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_arvalid (i_axi_arvalid),
		.o_arready (o_axi_arready),
		.i_araddr  (i_axi_araddr),
		.o_rvalid  (o_axi_rvalid),
		.i_rready  (i_axi_rready),
		.o_rdata   (o_axi_rdata),
		.o_rresp   (o_axi_rresp),
		.i_wb_data (i_wb_data),
		.wb        (wb_rd.master)
	);

	// One direction per bus cycle
	wb_rw_arbiter #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH)
	) u_arb (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.rd         (wb_rd.slave),
		.wr         (wb_wr.slave),
		.o_wb_cyc   (o_wb_cyc),
		.o_wb_stb   (o_wb_stb),
		.o_wb_we    (o_wb_we),
		.o_wb_addr  (o_wb_addr),
		.o_wb_data  (o_wb_data),
		.o_wb_sel   (o_wb_sel),
		.i_wb_stall (i_wb_stall),
		.i_wb_ack   (i_wb_ack),
		.i_wb_err   (i_wb_err)
	);

endmodule

// ==== design/wb_rw_arbiter.sv ====
`timescale 1ns/1ps

module wb_rw_arbiter #(
	parameter int ADDR_WIDTH = 28,
	parameter int DATA_WIDTH = 32,
	localparam int WB_AW     = ADDR_WIDTH - $clog2(DATA_WIDTH/8)
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	// The two halves
	wb_bus_if.slave                 rd,
	wb_bus_if.slave                 wr,
	// Shared outgoing bus
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output logic                    o_wb_we,
	output logic [WB_AW-1:0]        o_wb_addr,
	output logic [DATA_WIDTH-1:0]   o_wb_data,
	output logic [DATA_WIDTH/8-1:0] o_wb_sel,
	input  logic                    i_wb_stall,
	input  logic                    i_wb_ack,
	input  logic                    i_wb_err
);
	wb_pkg::arb_state_t state_q;
	wb_pkg::arb_state_t state_d;
	// Effective owner this cycle, idle grants combinationally
	wb_pkg::arb_state_t owner;
	wb_pkg::grant_t     last_q;
	logic               rd_sel;
	logic               wr_sel;

	//////////////////////////////////////////////////////////////////////
	// Grant FSM
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		owner = state_q;
		if (state_q == wb_pkg::ARB_IDLE)
		begin
			// Tie goes to whoever waited last time
			if (rd.cyc && wr.cyc)
				owner = (last_q == wb_pkg::GRANT_WRITE) ? wb_pkg::ARB_READ
					: wb_pkg::ARB_WRITE;
			else if (wr.cyc)
				owner = wb_pkg::ARB_WRITE;
			else if (rd.cyc)
				owner = wb_pkg::ARB_READ;
		end
	end

	// Keep the bus until the owner drops cyc
	always_comb
	begin
		case (owner)
			wb_pkg::ARB_READ:  state_d = rd.cyc ? wb_pkg::ARB_READ : wb_pkg::ARB_IDLE;
			wb_pkg::ARB_WRITE: state_d = wr.cyc ? wb_pkg::ARB_WRITE : wb_pkg::ARB_IDLE;
			default:           state_d = wb_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q <= wb_pkg::ARB_IDLE;
			// Read half wins the first tie
			last_q  <= wb_pkg::GRANT_WRITE;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == wb_pkg::ARB_IDLE && owner != wb_pkg::ARB_IDLE)
				last_q <= (owner == wb_pkg::ARB_WRITE) ? wb_pkg::GRANT_WRITE
					: wb_pkg::GRANT_READ;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request mux and response routing
	//////////////////////////////////////////////////////////////////////

	assign rd_sel = (owner == wb_pkg::ARB_READ);
	assign wr_sel = (owner == wb_pkg::ARB_WRITE);

	assign o_wb_cyc  = (rd_sel && rd.cyc) || (wr_sel && wr.cyc);
	assign o_wb_stb  = (rd_sel && rd.stb) || (wr_sel && wr.stb);
	assign o_wb_we   = wr_sel ? wr.we   : rd.we;
	assign o_wb_addr = wr_sel ? wr.addr : rd.addr;
	assign o_wb_data = wr_sel ? wr.data : rd.data;
	assign o_wb_sel  = wr_sel ? wr.sel  : rd.sel;

	// Loser just sees a stalled bus
	assign rd.stall = !rd_sel || i_wb_stall;
	assign rd.ack   = rd_sel && i_wb_ack;
	assign rd.err   = rd_sel && i_wb_err;

	assign wr.stall = !wr_sel || i_wb_stall;
	assign wr.ack   = wr_sel && i_wb_ack;
	assign wr.err   = wr_sel && i_wb_err;

endmodule

// ==== design/axil_rd_to_wb.sv ====
`timescale 1ns/1ps

module axil_rd_to_wb #(
	parameter int ADDR_WIDTH = 28,
	parameter int DATA_WIDTH = 32,
	parameter int LGFIFO     = 4
) (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	// AR channel
	input  logic                  i_arvalid,
	output logic                  o_arready,
	input  logic [ADDR_WIDTH-1:0] i_araddr,
	// R channel
	output logic                  o_rvalid,
	input  logic                  i_rready,
	output logic [DATA_WIDTH-1:0] o_rdata,
	output axil_pkg::resp_t       o_rresp,
	// Read data straight from the bus
	input  logic [DATA_WIDTH-1:0] i_wb_data,
	// Wishbone toward the arbiter
	wb_bus_if.master              wb
);
	localparam int ADDR_LSB = $clog2(DATA_WIDTH/8);
	localparam int WB_AW    = ADDR_WIDTH - ADDR_LSB;
	localparam int DEPTH    = 2**LGFIFO;

	typedef logic [WB_AW-1:0]      wb_addr_t;
	typedef logic [LGFIFO:0]       cnt_t;
	// Data in the upper bits, response in the low two
	typedef logic [DATA_WIDTH+1:0] rd_entry_t;

	logic      accept;
	logic      done;
	logic      credit;
	logic [LGFIFO+1:0] used;

	logic      stb_q;
	wb_addr_t  addr_q;
	cnt_t      outstanding_q;

	rd_entry_t fifo_mem [DEPTH];
	rd_entry_t fifo_head;
	cnt_t      fifo_wr_q;
	cnt_t      fifo_rd_q;
	cnt_t      fifo_fill;
	logic      fifo_pop;

	//////////////////////////////////////////////////////////////////////
	// AR to Wishbone read request
	//////////////////////////////////////////////////////////////////////

	assign done      = wb.ack | wb.err;
	assign fifo_fill = fifo_wr_q - fifo_rd_q;
	assign used      = {1'b0, outstanding_q} + {1'b0, fifo_fill};
	assign credit    = (used < (LGFIFO+2)'(DEPTH));

	// Same credit rule as the write half
	assign accept    = i_arvalid && credit && (!stb_q || !wb.stall);
	assign o_arready = accept;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			stb_q         <= 1'b0;
			outstanding_q <= '0;
		end
		else
		begin
			if (accept)
				stb_q <= 1'b1;
			else if (!wb.stall)
				stb_q <= 1'b0;
			outstanding_q <= outstanding_q + cnt_t'(accept) - cnt_t'(done);
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
			addr_q <= i_araddr[ADDR_WIDTH-1:ADDR_LSB];
	end

	// Whole-word reads, nothing on the data lines
	assign wb.cyc  = (outstanding_q != '0);
	assign wb.stb  = stb_q;
	assign wb.we   = 1'b0;
	assign wb.addr = addr_q;
	assign wb.data = '0;
	assign wb.sel  = '1;

	//////////////////////////////////////////////////////////////////////
	// R data and response FIFO
	//////////////////////////////////////////////////////////////////////

	assign fifo_pop = o_rvalid && i_rready;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			fifo_wr_q <= '0;
			fifo_rd_q <= '0;
		end
		else
		begin
			if (done)
				fifo_wr_q <= fifo_wr_q + 1'b1;
			if (fifo_pop)
				fifo_rd_q <= fifo_rd_q + 1'b1;
		end
	end

	// Data captured on ack, zeroed on err
	always_ff @(posedge i_clk)
	begin
		if (done)
		begin
			if (wb.err)
				fifo_mem[fifo_wr_q[LGFIFO-1:0]] <= {{DATA_WIDTH{1'b0}},
					axil_pkg::RESP_SLVERR};
			else
				fifo_mem[fifo_wr_q[LGFIFO-1:0]] <= {i_wb_data, axil_pkg::RESP_OKAY};
		end
	end

	assign fifo_head = fifo_mem[fifo_rd_q[LGFIFO-1:0]];
	assign o_rvalid  = (fifo_fill != '0);
	assign o_rdata   = fifo_head[DATA_WIDTH+1:2];
	assign o_rresp   = fifo_head[1:0];

endmodule

// ==== design/axil_wr_to_wb.sv ====
`timescale 1ns/1ps

module axil_wr_to_wb #(
	parameter int ADDR_WIDTH = 28,
	parameter int DATA_WIDTH = 32,
	parameter int LGFIFO     = 4
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	// AW channel
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [ADDR_WIDTH-1:0]   i_awaddr,
	// W channel
	input  logic                    i_wvalid,
	output logic                    o_wready,
	input  logic [DATA_WIDTH-1:0]   i_wdata,
	input  logic [DATA_WIDTH/8-1:0] i_wstrb,
	// B channel
	output logic                    o_bvalid,
	input  logic                    i_bready,
	output axil_pkg::resp_t         o_bresp,
	// Wishbone toward the arbiter
	wb_bus_if.master                wb
);
	localparam int ADDR_LSB = $clog2(DATA_WIDTH/8);
	localparam int WB_AW    = ADDR_WIDTH - ADDR_LSB;
	localparam int DEPTH    = 2**LGFIFO;

	// Word address, byte offset dropped
	typedef logic [WB_AW-1:0]      wb_addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	// Counts 0..DEPTH inclusive
	typedef logic [LGFIFO:0]       cnt_t;

	logic                    accept;
	logic                    done;
	logic                    credit;
	logic [LGFIFO+1:0]       used;

	// Registered request
	logic                    stb_q;
	wb_addr_t                addr_q;
	data_t                   data_q;
	logic [DATA_WIDTH/8-1:0] sel_q;
	// Accepted, not yet acked
	cnt_t                    outstanding_q;

	// B response queue
	axil_pkg::resp_t         fifo_mem [DEPTH];
	cnt_t                    fifo_wr_q;
	cnt_t                    fifo_rd_q;
	cnt_t                    fifo_fill;
	logic                    fifo_pop;

	//////////////////////////////////////////////////////////////////////
	// AW/W merge and credit
	//////////////////////////////////////////////////////////////////////

	// One ack or err per request
	assign done      = wb.ack | wb.err;
	assign fifo_fill = fifo_wr_q - fifo_rd_q;

	// Every in-flight request owns a FIFO slot already
	assign used      = {1'b0, outstanding_q} + {1'b0, fifo_fill};
	assign credit    = (used < (LGFIFO+2)'(DEPTH));

	// Both channels together, and the request register free or leaving
	assign accept    = i_awvalid && i_wvalid && credit && (!stb_q || !wb.stall);
	assign o_awready = accept;
	assign o_wready  = accept;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			stb_q         <= 1'b0;
			outstanding_q <= '0;
		end
		else
		begin
			// Hold stb through stall
			if (accept)
				stb_q <= 1'b1;
			else if (!wb.stall)
				stb_q <= 1'b0;
			outstanding_q <= outstanding_q + cnt_t'(accept) - cnt_t'(done);
		end
	end

	// Merged address, data and strobes
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			addr_q <= i_awaddr[ADDR_WIDTH-1:ADDR_LSB];
			data_q <= i_wdata;
			sel_q  <= i_wstrb;
		end
	end

	// Cycle open while anything is in flight
	assign wb.cyc  = (outstanding_q != '0);
	assign wb.stb  = stb_q;
	assign wb.we   = 1'b1;
	assign wb.addr = addr_q;
	assign wb.data = data_q;
	assign wb.sel  = sel_q;

	//////////////////////////////////////////////////////////////////////
	// B response FIFO
	//////////////////////////////////////////////////////////////////////

	assign fifo_pop = o_bvalid && i_bready;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			fifo_wr_q <= '0;
			fifo_rd_q <= '0;
		end
		else
		begin
			if (done)
				fifo_wr_q <= fifo_wr_q + 1'b1;
			if (fifo_pop)
				fifo_rd_q <= fifo_rd_q + 1'b1;
		end
	end

	// Err takes priority, ack alone is OKAY
	always_ff @(posedge i_clk)
	begin
		if (done)
			fifo_mem[fifo_wr_q[LGFIFO-1:0]] <= wb.err ? axil_pkg::RESP_SLVERR
				: axil_pkg::RESP_OKAY;
	end

	// Head entry stays put until bready
	assign o_bvalid = (fifo_fill != '0);
	assign o_bresp  = fifo_mem[fifo_rd_q[LGFIFO-1:0]];

endmodule

// ==== design/wb_bus_if.sv ====
`timescale 1ns/1ps

// Pipelined Wishbone bundle between one bridge half and the arbiter
interface wb_bus_if #(
	parameter int AW = 26,
	parameter int DW = 32
);
	// Request side, master to slave
	logic            cyc;
	logic            stb;
	logic            we;
	logic [AW-1:0]   addr;
	logic [DW-1:0]   data;
	logic [DW/8-1:0] sel;

	// Response side, slave to master
	logic            stall;
	logic            ack;
	logic            err;

	// Bridge half view
	modport master (
		output cyc, stb, we, addr, data, sel,
		input  stall, ack, err
	);

	// Arbiter view
	modport slave (
		input  cyc, stb, we, addr, data, sel,
		output stall, ack, err
	);

endinterface

// ==== design/wb_pkg.sv ====
// Wishbone side definitions for the shared bus arbiter
package wb_pkg;

	// Current bus owner
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_READ  = 2'd1,
		ARB_WRITE = 2'd2
	} arb_state_t;

	// Side granted most recently, for round-robin
	typedef logic grant_t;

	// Read half last
	localparam grant_t GRANT_READ  = 1'b0;
	// Write half last
	localparam grant_t GRANT_WRITE = 1'b1;

endpackage

// ==== design/axil_pkg.sv ====
// AXI4-Lite side definitions shared by the bridge halves and the top level
package axil_pkg;

	////////////////////////////////////////////////////////////////////
	// Response codes
	////////////////////////////////////////////////////////////////////

	// BRESP / RRESP encoding
	typedef logic [1:0] resp_t;

	// Normal completion
	localparam resp_t RESP_OKAY   = 2'b00;
	// Wishbone err maps here
	localparam resp_t RESP_SLVERR = 2'b10;

	////////////////////////////////////////////////////////////////////
	// Channel payload types
	////////////////////////////////////////////////////////////////////

	// AxPROT, carried on the ports but not decoded
	typedef logic [2:0] prot_t;

	// Byte address width default
	localparam int ADDR_WIDTH_DEF = 28;
	// Data bus width default, bytes derived from it
	localparam int DATA_WIDTH_DEF = 32;

endpackage
